// ==== Makefile ====
# Verilator build and run for the USB 3.0 receive path testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps -f sources.f \
		--top-module tb_usb3_dev_top -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vtb_usb3_dev_top > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/link_stream_if.sv ====
/*
 * valid/ready stream of link words; word is held stable from valid until accepted.
 * overrun is a sticky flag that travels alongside from the source
 */

`timescale 1ns/10ps

interface link_stream_if import usb3_link_pkg::*; ();

	logic       valid;
	logic       ready;
	link_word_t word;
	logic       overrun;	// sticky, word dropped somewhere upstream

	modport source (output valid, output word, output overrun, input ready);
	modport sink   (input valid, input word, input overrun, output ready);

endinterface

// ==== rtl/usb3_dev_top.sv ====
/*
 * USB 3.0 device receive path: PIPE beats to per-endpoint output stream.
 * single clock local_pclk_half; PIPE receive has no back-pressure, see rx_overflow
 */

`timescale 1ns/10ps

module usb3_dev_top import usb3_pipe_pkg::*, usb3_link_pkg::*; (
	input  logic                   local_pclk_half,
	input  logic                   rst_n,
	input  logic                   pll_locked,
	input  logic                   phy_pwrpresent,

	input  logic [PIPE_DATA_W-1:0] phy_rx_data,
	input  logic [PIPE_K_W-1:0]    phy_rx_datak,
	input  logic                   phy_rx_valid,
	input  logic [TX_MARGIN_W-1:0] tx_margin_cfg,
	output logic [TX_MARGIN_W-1:0] phy_tx_margin,

	output logic                   out_valid,
	input  logic                   out_ready,
	output logic [LINK_DATA_W-1:0] out_data,
	output logic [ENDP_W-1:0]      out_endp,
	output logic                   rx_overflow
);

	logic                                 link_rst_n;
	logic [NUM_ENDP-1:0]                  wr_valid;
	logic [NUM_ENDP-1:0]                  wr_ready;
	logic [NUM_ENDP-1:0][LINK_DATA_W-1:0] wr_data;
	logic [NUM_ENDP-1:0]                  rd_valid;
	logic [NUM_ENDP-1:0]                  rd_ready;
	logic [NUM_ENDP-1:0][LINK_DATA_W-1:0] rd_data;

	link_stream_if link_s ();

	assign rx_overflow = link_s.overrun;

	////////////////////////////////////////////////////////////////////////////
	// reset, straps and PIPE receive

	usb3_reset_strap irst (
		.local_pclk_half (local_pclk_half),
		.rst_n           (rst_n),
		.pll_locked      (pll_locked),
		.phy_pwrpresent  (phy_pwrpresent),
		.tx_margin_cfg   (tx_margin_cfg),
		.link_rst_n      (link_rst_n),
		.phy_tx_margin   (phy_tx_margin)
	);

	usb3_rx_packer ipack (
		.local_pclk_half (local_pclk_half),
		.link_rst_n      (link_rst_n),
		.phy_rx_data     (phy_rx_data),
		.phy_rx_datak    (phy_rx_datak),
		.phy_rx_valid    (phy_rx_valid),
		.link_out        (link_s.source)
	);

	////////////////////////////////////////////////////////////////////////////
	// endpoint routing and buffering

	usb3_endp_router iroute (
		.local_pclk_half (local_pclk_half),
		.link_rst_n      (link_rst_n),
		.link_in         (link_s.sink),
		.wr_ready        (wr_ready),
		.wr_valid        (wr_valid),
		.wr_data         (wr_data)
	);

	for (genvar i = 0; i < NUM_ENDP; i++) begin : g_endp
		usb3_endp_fifo ififo (
			.local_pclk_half (local_pclk_half),
			.link_rst_n      (link_rst_n),
			.wr_valid        (wr_valid[i]),
			.wr_data         (wr_data[i]),
			.wr_ready        (wr_ready[i]),
			.rd_valid        (rd_valid[i]),
			.rd_ready        (rd_ready[i]),
			.rd_data         (rd_data[i])
		);
	end

	usb3_tx_arbiter iarb (
		.local_pclk_half (local_pclk_half),
		.link_rst_n      (link_rst_n),
		.rd_valid        (rd_valid),
		.rd_data         (rd_data),
		.rd_ready        (rd_ready),
		.out_valid       (out_valid),
		.out_ready       (out_ready),
		.out_data        (out_data),
		.out_endp        (out_endp)
	);

endmodule

// ==== rtl/usb3_endp_fifo.sv ====
/*
 * Per-endpoint FIFO of FIFO_DEPTH link data words.
 * written word shows on rd_valid the next cycle, wr_ready low while full
 */

`timescale 1ns/10ps

module usb3_endp_fifo import usb3_link_pkg::*; (
	input  logic                   local_pclk_half,
	input  logic                   link_rst_n,
	input  logic                   wr_valid,
	input  logic [LINK_DATA_W-1:0] wr_data,
	output logic                   wr_ready,
	output logic                   rd_valid,
	input  logic                   rd_ready,
	output logic [LINK_DATA_W-1:0] rd_data
);

	typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(FIFO_DEPTH):0]   cnt_t;

	logic [LINK_DATA_W-1:0] mem [FIFO_DEPTH];
	ptr_t                   wr_ptr;
	ptr_t                   rd_ptr;
	cnt_t                   count;
	logic                   push;
	logic                   pop;

	function automatic ptr_t next_ptr(input ptr_t p);
		return (p == ptr_t'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign wr_ready = (count != cnt_t'(FIFO_DEPTH));
	assign rd_valid = (count != '0);
	assign rd_data  = mem[rd_ptr];
	assign push     = wr_valid & wr_ready;
	assign pop      = rd_valid & rd_ready;

	always_ff @(posedge local_pclk_half or negedge link_rst_n) begin
		if (!link_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge local_pclk_half) begin
		if (push)
			mem[wr_ptr] <= wr_data;
	end

endmodule

// ==== rtl/usb3_endp_router.sv ====
/*
 * Steers data words to the endpoint named by the last SHP header.
 * headers, other K-words and words on a closed route are consumed without output
 */

`timescale 1ns/10ps

module usb3_endp_router import usb3_link_pkg::*; (
	input  logic                                 local_pclk_half,
	input  logic                                 link_rst_n,
	link_stream_if.sink                          link_in,
	input  logic [NUM_ENDP-1:0]                  wr_ready,
	output logic [NUM_ENDP-1:0]                  wr_valid,
	output logic [NUM_ENDP-1:0][LINK_DATA_W-1:0] wr_data
);

	link_word_t              w;
	logic                    is_hdr;
	logic                    is_data;		// no K flags at all
	logic                    fwd;
	logic [ENDP_FIELD_W-1:0] hdr_endp;
	logic [ENDP_W-1:0]       cur_endp;
	logic                    route_open;

	assign w        = link_in.word;
	assign is_hdr   = w.datak[0] && (w.data[7:0] == K_SHP);
	assign is_data  = (w.datak == '0);
	assign hdr_endp = w.data[HDR_ENDP_LSB +: ENDP_FIELD_W];
	assign fwd      = is_data & route_open;

	// no extra cycle, stall only when the chosen buffer is full
	assign link_in.ready = fwd ? wr_ready[cur_endp] : 1'b1;

	always_comb begin
		for (int i = 0; i < NUM_ENDP; i++) begin
			wr_valid[i] = link_in.valid & fwd & (cur_endp == ENDP_W'(i));
			wr_data[i]  = w.data;
		end
	end

	// header always accepted, so valid alone is a transfer here
	always_ff @(posedge local_pclk_half or negedge link_rst_n) begin
		if (!link_rst_n) begin
			cur_endp   <= '0;
			route_open <= 1'b0;
		end else if (link_in.valid && is_hdr) begin
			cur_endp   <= hdr_endp[ENDP_W-1:0];
			route_open <= (hdr_endp < ENDP_FIELD_W'(NUM_ENDP));	// out of range closes
		end
	end

endmodule

// ==== rtl/usb3_link_pkg.sv ====
/*
 * Link word format and endpoint buffering constants.
 * header decode looks only at the SHP K-code in byte 0 and the endpoint field
 */

package usb3_link_pkg;

	localparam int LINK_DATA_W = 32;
	localparam int LINK_K_W    = 4;

	// start of header packet K-code
	localparam logic [7:0] K_SHP = 8'h5c;

	// endpoint field sits at bits 11:8 of a header word
	localparam int HDR_ENDP_LSB = 8;
	localparam int ENDP_FIELD_W = 4;

	// endpoint buffering
	localparam int NUM_ENDP   = 4;
	localparam int ENDP_W     = 2;		// index width for NUM_ENDP
	localparam int FIFO_DEPTH = 4;		// words per endpoint

	// link word with its per-byte K flags
	typedef struct packed {
		logic [LINK_DATA_W-1:0] data;
		logic [LINK_K_W-1:0]    datak;
	} link_word_t;

endpackage

// ==== rtl/usb3_pipe_pkg.sv ====
/*
 * PIPE side constants for a 16-bit SDR PIPE3 PHY.
 * strap value assumes a PHY that samples tx_margin as its SSC select during reset
 */

package usb3_pipe_pkg;

	// receive beat as delivered by the PHY
	localparam int PIPE_DATA_W = 16;
	localparam int PIPE_K_W    = 2;		// one K flag per byte

	// transmit margin pins, doubling as straps while in reset
	localparam int TX_MARGIN_W = 3;

	// spread spectrum clocking disabled
	localparam logic [TX_MARGIN_W-1:0] STRAP_SSC_DIS = 3'b011;

	// flops in the reset release synchronizer
	localparam int RST_SYNC_STAGES = 2;

endpackage

// ==== rtl/usb3_reset_strap.sv ====
/*
 * Local reset from external reset, PLL lock and VBUS present.
 * asserts asynchronously, releases after RST_SYNC_STAGES edges of local_pclk_half
 */

`timescale 1ns/10ps

module usb3_reset_strap import usb3_pipe_pkg::*; (
	input  logic                   local_pclk_half,
	input  logic                   rst_n,
	input  logic                   pll_locked,
	input  logic                   phy_pwrpresent,
	input  logic [TX_MARGIN_W-1:0] tx_margin_cfg,
	output logic                   link_rst_n,
	output logic [TX_MARGIN_W-1:0] phy_tx_margin
);

	logic                       local_ok;		// all qualifiers present
	logic [RST_SYNC_STAGES-1:0] sync_q;

	assign local_ok = rst_n & pll_locked & phy_pwrpresent;

	// any qualifier dropping resets at once, release is synchronized
	always_ff @(posedge local_pclk_half or negedge local_ok) begin
		if (!local_ok) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[RST_SYNC_STAGES-2:0], 1'b1};
		end
	end

	assign link_rst_n = sync_q[RST_SYNC_STAGES-1];

	// PHY samples margin pins as straps while we hold it in reset
	assign phy_tx_margin = link_rst_n ? tx_margin_cfg : STRAP_SSC_DIS;

endmodule

// ==== rtl/usb3_rx_packer.sv ====
/*
 * Packs pairs of 16-bit PIPE beats into 32-bit link words, low beat first.
 * PIPE receive cannot stall: a word completing while the last is unaccepted is dropped
 * and overrun sticks high until link reset
 */

`timescale 1ns/10ps

module usb3_rx_packer import usb3_pipe_pkg::*, usb3_link_pkg::*; (
	input  logic                   local_pclk_half,
	input  logic                   link_rst_n,
	input  logic [PIPE_DATA_W-1:0] phy_rx_data,
	input  logic [PIPE_K_W-1:0]    phy_rx_datak,
	input  logic                   phy_rx_valid,
	link_stream_if.source          link_out
);

	logic                   hi_half;	// next beat fills the high half
	logic [PIPE_DATA_W-1:0] lo_data;
	logic [PIPE_K_W-1:0]    lo_k;
	link_word_t             word_q;
	logic                   valid_q;
	logic                   overrun_q;
	logic                   word_done;	// second beat of a pair this cycle
	logic                   hold_busy;	// held word not taken this cycle

	assign word_done = phy_rx_valid & hi_half;
	assign hold_busy = valid_q & ~link_out.ready;

	////////////////////////////////////////////////////////////////////////////
	// half tracking and output handshake

	always_ff @(posedge local_pclk_half or negedge link_rst_n) begin
		if (!link_rst_n) begin
			hi_half   <= 1'b0;
			valid_q   <= 1'b0;
			overrun_q <= 1'b0;
		end else begin
			if (phy_rx_valid)
				hi_half <= ~hi_half;

			if (word_done && hold_busy)
				overrun_q <= 1'b1;		// new word lost

			if (word_done && !hold_busy)
				valid_q <= 1'b1;
			else if (link_out.ready)
				valid_q <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// word assembly

	always_ff @(posedge local_pclk_half) begin
		if (phy_rx_valid && !hi_half) begin
			lo_data <= phy_rx_data;
			lo_k    <= phy_rx_datak;
		end
		if (word_done && !hold_busy) begin
			word_q.data  <= {phy_rx_data, lo_data};
			word_q.datak <= {phy_rx_datak, lo_k};
		end
	end

	assign link_out.valid   = valid_q;
	assign link_out.word    = word_q;
	assign link_out.overrun = overrun_q;

endmodule

// ==== rtl/usb3_tx_arbiter.sv ====
/*
 * Round-robin drain of the endpoint FIFOs into one registered output stream.
 * search starts one past the last granted endpoint; endpoint 0 first after reset
 */

`timescale 1ns/10ps

module usb3_tx_arbiter import usb3_link_pkg::*; (
	input  logic                                 local_pclk_half,
	input  logic                                 link_rst_n,
	input  logic [NUM_ENDP-1:0]                  rd_valid,
	input  logic [NUM_ENDP-1:0][LINK_DATA_W-1:0] rd_data,
	output logic [NUM_ENDP-1:0]                  rd_ready,
	output logic                                 out_valid,
	input  logic                                 out_ready,
	output logic [LINK_DATA_W-1:0]               out_data,
	output logic [ENDP_W-1:0]                    out_endp
);

	logic              load_ok;	// output register free or leaving
	logic              found;
	logic [ENDP_W-1:0] gnt;
	logic [ENDP_W-1:0] last_q;	// last granted endpoint
	logic              take;

	assign load_ok = ~out_valid | out_ready;
	assign take    = load_ok & found;

	////////////////////////////////////////////////////////////////////////////
	// grant search, upward from last_q + 1 with wrap

	always_comb begin
		logic [ENDP_W-1:0] idx;

		found = 1'b0;
		gnt   = last_q;
		for (int k = 1; k <= NUM_ENDP; k++) begin
			idx = ENDP_W'((int'(last_q) + k) % NUM_ENDP);
			if (!found && rd_valid[idx]) begin
				found = 1'b1;
				gnt   = idx;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_ENDP; i++)
			rd_ready[i] = take & (gnt == ENDP_W'(i));
	end

	////////////////////////////////////////////////////////////////////////////
	// output register

	always_ff @(posedge local_pclk_half or negedge link_rst_n) begin
		if (!link_rst_n) begin
			out_valid <= 1'b0;
			last_q    <= ENDP_W'(NUM_ENDP - 1);	// so endpoint 0 is tried first
		end else if (take) begin
			out_valid <= 1'b1;
			last_q    <= gnt;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// holds under back-pressure since take needs load_ok
	always_ff @(posedge local_pclk_half) begin
		if (take) begin
			out_data <= rd_data[gnt];
			out_endp <= gnt;
		end
	end

endmodule

// ==== sources.f ====
rtl/usb3_pipe_pkg.sv
rtl/usb3_link_pkg.sv
rtl/link_stream_if.sv
rtl/usb3_reset_strap.sv
rtl/usb3_rx_packer.sv
rtl/usb3_endp_router.sv
rtl/usb3_endp_fifo.sv
rtl/usb3_tx_arbiter.sv
rtl/usb3_dev_top.sv
test/usb3_dev_props.sv
test/tb_usb3_dev_top.sv

// ==== test/tb_usb3_dev_top.sv ====
/*
 * Directed tests for the receive path, PIPE beats in, endpoint stream out.
 * beats are spaced by GAP idle cycles so the packer never overruns
 */

`timescale 1ns/10ps

module tb_usb3_dev_top import usb3_pipe_pkg::*, usb3_link_pkg::*; ();

	localparam int CLK_PERIOD  = 100;
	localparam int GAP         = 4;			// idle cycles after each word
	localparam int WORDS_SENT  = 33;		// summed over all tests
	localparam int WDOG_CYCLES = WORDS_SENT * 40 + 200;

	logic                   local_pclk_half;
	logic                   rst_n;
	logic                   pll_locked;
	logic                   phy_pwrpresent;
	logic [PIPE_DATA_W-1:0] phy_rx_data;
	logic [PIPE_K_W-1:0]    phy_rx_datak;
	logic                   phy_rx_valid;
	logic [TX_MARGIN_W-1:0] tx_margin_cfg;
	logic [TX_MARGIN_W-1:0] phy_tx_margin;
	logic                   out_valid;
	logic                   out_ready;
	logic [LINK_DATA_W-1:0] out_data;
	logic [ENDP_W-1:0]      out_endp;
	logic                   rx_overflow;

	// reference model state
	logic [LINK_DATA_W-1:0] exp_q [NUM_ENDP][$];
	logic [ENDP_W-1:0]      seen_endp[$];		// endpoints in arrival order
	logic [ENDP_FIELD_W-1:0] m_endp;
	bit                     m_open;
	logic [LINK_DATA_W-1:0] want;
	logic [31:0]            seed = 32'd89540;
	bit                     rand_ready;
	int                     errors;

	usb3_dev_top dut_i (.*);

	initial begin
		local_pclk_half = 1'b0;
		forever #(CLK_PERIOD / 2) local_pclk_half = ~local_pclk_half;
	end

	initial begin
		#(WDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [31:0] hdr(input logic [3:0] ep);
		return {16'h0000, 4'h0, ep, K_SHP};
	endfunction

	function automatic int pending();
		int n;
		n = 0;
		for (int i = 0; i < NUM_ENDP; i++)
			n += exp_q[i].size();
		return n;
	endfunction

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// one rising edge, with a fresh out_ready when randomized
	task automatic tick();
		@(posedge local_pclk_half);
		if (rand_ready) begin
			seed = lcg_next(seed);
			out_ready <= seed[16];
		end
	endtask

	task automatic send_word(input logic [31:0] d, input logic [3:0] k);
		if (k[0] && d[7:0] == K_SHP) begin
			m_endp = d[HDR_ENDP_LSB +: ENDP_FIELD_W];
			m_open = (m_endp < ENDP_FIELD_W'(NUM_ENDP));
		end else if (k == 4'b0000 && m_open) begin
			exp_q[m_endp[ENDP_W-1:0]].push_back(d);
		end
		tick();
		phy_rx_data  <= d[15:0];		// low beat first
		phy_rx_datak <= k[1:0];
		phy_rx_valid <= 1'b1;
		tick();
		phy_rx_data  <= d[31:16];
		phy_rx_datak <= k[3:2];
		tick();
		phy_rx_valid <= 1'b0;
		repeat (GAP) tick();
	endtask

	task automatic send_data(input int n);
		for (int i = 0; i < n; i++) begin
			seed = lcg_next(seed);
			send_word(seed, 4'b0000);
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (pending() != 0 && n < 300) begin
			tick();
			n++;
		end
		assert (pending() == 0) else begin
			$display("output stalled, %0d expected words never arrived", pending());
			errors++;
		end
		repeat (8) tick();	// room for stray words to show
	endtask

	task automatic report(input string name, input int e0);
		$display("%s finished, %0d errors", name, errors - e0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// output monitor, sampled mid-cycle

	always @(negedge local_pclk_half) begin
		if (out_valid && out_ready) begin
			seen_endp.push_back(out_endp);
			assert (exp_q[out_endp].size() > 0) else begin
				$display("unexpected word %h came out on endpoint %0d", out_data, out_endp);
				errors++;
			end
			if (exp_q[out_endp].size() > 0) begin
				want = exp_q[out_endp].pop_front();
				expect_eq("out_data", out_data, want);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// tests

	task automatic test_reset();
		int e0;
		e0 = errors;
		repeat (8) begin
			@(negedge local_pclk_half);
			expect_eq("phy_tx_margin in reset", 32'(phy_tx_margin), 32'(STRAP_SSC_DIS));
			expect_eq("out_valid in reset", 32'(out_valid), 32'd0);
		end
		tick();
		rst_n <= 1'b1;		// PLL still unlocked
		repeat (3) begin
			@(negedge local_pclk_half);
			expect_eq("phy_tx_margin, pll unlocked", 32'(phy_tx_margin), 32'(STRAP_SSC_DIS));
		end
		tick();
		pll_locked <= 1'b1;
		tick();
		@(negedge local_pclk_half);
		expect_eq("phy_tx_margin, first edge", 32'(phy_tx_margin), 32'(STRAP_SSC_DIS));
		tick();
		@(negedge local_pclk_half);
		expect_eq("phy_tx_margin after release", 32'(phy_tx_margin), 32'h5);
		tick();
		tx_margin_cfg <= 3'b110;
		@(negedge local_pclk_half);
		expect_eq("phy_tx_margin follows cfg", 32'(phy_tx_margin), 32'h6);
		report("reset_strap", e0);
	endtask

	task automatic test_single_endp();
		int e0;
		e0 = errors;
		seen_endp.delete();
		send_word(hdr(4'd2), 4'b0001);
		send_data(3);
		wait_drain();
		expect_eq("words on endpoint 2", 32'(seen_endp.size()), 32'd3);
		foreach (seen_endp[i])
			expect_eq("out_endp", 32'(seen_endp[i]), 32'd2);
		report("single_endp", e0);
	endtask

	task automatic test_discard();
		int e0;
		e0 = errors;
		seen_endp.delete();
		send_word({24'h000000, 8'hbc}, 4'b0001);	// K-word, not SHP
		send_word(hdr(4'd5), 4'b0001);
		send_data(2);
		send_word(hdr(4'd1), 4'b0001);
		send_data(2);
		wait_drain();
		expect_eq("delivered words", 32'(seen_endp.size()), 32'd2);
		report("discard", e0);
	endtask

	task automatic test_round_robin();
		int e0;
		e0 = errors;
		seen_endp.delete();
		tick();
		out_ready <= 1'b0;
		send_word(hdr(4'd1), 4'b0001);
		send_data(2);
		send_word(hdr(4'd3), 4'b0001);
		send_data(2);
		tick();
		out_ready <= 1'b1;
		wait_drain();
		expect_eq("round-robin words", 32'(seen_endp.size()), 32'd4);
		foreach (seen_endp[i])
			expect_eq("grant order", 32'(seen_endp[i]), (i % 2 != 0) ? 32'd3 : 32'd1);
		report("round_robin", e0);
	endtask

	task automatic test_backpressure();
		int e0;
		e0 = errors;
		seen_endp.delete();
		rand_ready = 1'b1;
		for (int h = 0; h < NUM_ENDP; h++) begin
			send_word(hdr(4'(h ^ 2)), 4'b0001);	// order 2, 3, 0, 1
			send_data(3);
		end
		wait_drain();
		rand_ready = 1'b0;
		tick();
		out_ready <= 1'b1;
		expect_eq("words under back-pressure", 32'(seen_endp.size()), 32'd12);
		expect_eq("rx_overflow", 32'(rx_overflow), 32'd0);
		report("backpressure", e0);
	endtask

	initial begin
		rst_n          <= 1'b0;
		pll_locked     <= 1'b0;
		phy_pwrpresent <= 1'b1;
		phy_rx_data    <= '0;
		phy_rx_datak   <= '0;
		phy_rx_valid   <= 1'b0;
		tx_margin_cfg  <= 3'b101;
		out_ready      <= 1'b1;
		rand_ready     = 1'b0;
		m_open         = 1'b0;
		m_endp         = '0;
		errors         = 0;

		test_reset();
		test_single_endp();
		test_discard();
		test_round_robin();
		test_backpressure();

		$display("tests run: 5, errors: %0d", errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== test/usb3_dev_props.sv ====
/*
 * Checks on the arbiter output stream and on the reset strap pins.
 * bound into both modules; output checks live in the arbiter, strap checks in the reset block
 */

`timescale 1ns/10ps

module usb3_dev_props import usb3_pipe_pkg::*, usb3_link_pkg::*; #(
	parameter bit CHECK_OUT   = 1'b1,
	parameter bit CHECK_STRAP = 1'b1
) (
	input logic                   local_pclk_half,
	input logic                   link_rst_n,
	input logic                   rst_n,
	input logic                   pll_locked,
	input logic                   phy_pwrpresent,
	input logic                   out_valid,
	input logic                   out_ready,
	input logic [LINK_DATA_W-1:0] out_data,
	input logic [ENDP_W-1:0]      out_endp,
	input logic [TX_MARGIN_W-1:0] phy_tx_margin
);

	if (CHECK_OUT) begin : g_out
		// stalled output register must hold its word and endpoint
		hold_when_stalled: assert property (@(posedge local_pclk_half) disable iff (!link_rst_n)
			out_valid && !out_ready |=> $stable(out_data) && $stable(out_endp))
			else $error("out_data or out_endp changed under back-pressure");

		quiet_in_reset: assert property (@(posedge local_pclk_half) !link_rst_n |-> !out_valid)
			else $error("out_valid high while link reset is active");
	end

	if (CHECK_STRAP) begin : g_strap
		// any missing qualifier puts the straps out at once
		strap_in_reset: assert property (@(posedge local_pclk_half)
			!(rst_n && pll_locked && phy_pwrpresent) |-> phy_tx_margin == STRAP_SSC_DIS)
			else $error("phy_tx_margin not at the SSC strap value during reset");
	end

endmodule

bind usb3_tx_arbiter usb3_dev_props #(.CHECK_OUT(1'b1), .CHECK_STRAP(1'b0)) arb_props_i (
	.local_pclk_half (local_pclk_half),
	.link_rst_n      (link_rst_n),
	.rst_n           (1'b1),
	.pll_locked      (1'b1),
	.phy_pwrpresent  (1'b1),
	.out_valid       (out_valid),
	.out_ready       (out_ready),
	.out_data        (out_data),
	.out_endp        (out_endp),
	.phy_tx_margin   (usb3_pipe_pkg::STRAP_SSC_DIS)	// no margin pins here
);

bind usb3_reset_strap usb3_dev_props #(.CHECK_OUT(1'b0), .CHECK_STRAP(1'b1)) strap_props_i (
	.local_pclk_half (local_pclk_half),
	.link_rst_n      (link_rst_n),
	.rst_n           (rst_n),
	.pll_locked      (pll_locked),
	.phy_pwrpresent  (phy_pwrpresent),
	.out_valid       (1'b0),
	.out_ready       (1'b1),
	.out_data        ('0),
	.out_endp        ('0),
	.phy_tx_margin   (phy_tx_margin)
);
